/* Makefile */
# Verilator build for the RMS normalization unit and its testbench

VERILATOR  ?= verilator
TOP        ?= tb_rms_norm
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
EXTRA      ?=

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) $(EXTRA)

# The simulator exits with a failing status on any fatal check
run: build
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP) $(EXTRA)

clean:
	rm -rf $(BUILD_DIR)

/* sim/clock_gen.sv */
// Testbench clock and reset generator
// Free-running clock and an active-low reset held for a few cycles.

`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* sim/rms_ref.svh */
// RMS normalization reference model
// Fixed-point golden model of one vector, plus the Galois LFSR that
// feeds all random stimulus. Included inside the testbench module.

`ifndef RMS_REF_SVH
`define RMS_REF_SVH

logic [31:0] lfsr_state = 32'h0861bcdf;

// One LFSR step per bit taken
function automatic logic [31:0] next_random_bits(int n);
    logic [31:0] bits;
    logic        out_bit;
    bits = '0;
    for (int i = 0; i < n; i++) begin
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        bits = {bits[30:0], out_bit};
    end
    return bits;
endfunction

// Mean of squares in Q4, through the fixed reciprocal of N
function automatic longint mean_square_of(in_vec_t x);
    longint sum;
    longint v;
    longint ms;
    sum = 0;
    for (int b = 0; b < NUM_ITERS; b++) begin
        for (int l = 0; l < LANES; l++) begin
            v   = longint'($signed(x[b].lane[l]));
            sum = sum + v * v;
        end
    end
    ms = (sum * ((longint'(1) << 32) / NUM_VALUES)) >>> 32;
    return (ms > 65535) ? 65535 : ms;
endfunction

// Floor of sqrt(ms * 16), a Q4 root
function automatic longint root_of(longint ms);
    longint rad;
    longint r;
    rad = ms * 16;
    r   = 0;
    while ((r + 1) * (r + 1) <= rad) begin
        r++;
    end
    return r;
endfunction

function automatic longint inverse_root_of(longint r);
    longint q;
    if (r == 0) begin
        return 65535;
    end
    q = 4096 / r;
    return (q > 65535) ? 65535 : q;
endfunction

function automatic logic [OUT_WIDTH-1:0] scaled_lane(longint inv, logic [IN_WIDTH-1:0] x,
                                                     logic [W_WIDTH-1:0] w);
    longint affine;
    longint shifted;
    affine  = inv * longint'($signed(x)) * longint'($signed(w));
    // Q12 down to Q4 with floor
    shifted = affine >>> 8;
    if (shifted > 127) begin
        shifted = 127;
    end else if (shifted < -128) begin
        shifted = -128;
    end
    return OUT_WIDTH'(shifted);
endfunction

function automatic out_vec_t expected_vector(in_vec_t x, w_vec_t w);
    out_vec_t y;
    longint   inv;
    inv = inverse_root_of(root_of(mean_square_of(x)));
    for (int b = 0; b < NUM_ITERS; b++) begin
        for (int l = 0; l < LANES; l++) begin
            y[b].lane[l] = scaled_lane(inv, x[b].lane[l], w[b].lane[l]);
        end
    end
    return y;
endfunction

`endif

/* sim/tb_rms_norm.sv */
// RMS normalization testbench
// Streams vectors and weights into the DUT with optional gaps and
// output back-pressure, and checks every output tile against the
// reference model in order.

`timescale 1ns/10ps
`default_nettype none

module tb_rms_norm #(
    parameter int TOTAL_DIM0 = 4,
    parameter int TOTAL_DIM1 = 4,
    parameter int CHANNELS   = 2
);
    import rms_norm_pkg::*;

    localparam int NUM_ITERS  = TOTAL_DIM0 * TOTAL_DIM1 * CHANNELS / LANES;
    localparam int NUM_VALUES = NUM_ITERS * LANES;

    typedef in_tile_t  [NUM_ITERS-1:0] in_vec_t;
    typedef w_tile_t   [NUM_ITERS-1:0] w_vec_t;
    typedef out_tile_t [NUM_ITERS-1:0] out_vec_t;

    `include "rms_ref.svh"

    logic      clk;
    logic      rst_n;
    in_tile_t  in_tile;
    logic      in_valid;
    logic      in_ready;
    w_tile_t   weight_tile;
    logic      weight_valid;
    logic      weight_ready;
    out_tile_t out_tile;
    logic      out_valid;
    logic      out_ready;

    in_tile_t  in_q[$];
    w_tile_t   w_q[$];
    out_tile_t exp_q[$];
    logic      gaps_on;
    logic      ready_random;
    int        out_count;

    clock_gen #(.PERIOD(10), .RESET_CYCLES(3)) u_clock_gen (.clk(clk), .rst_n(rst_n));

    rms_norm_2d #(
        .TOTAL_DIM0 (TOTAL_DIM0),
        .TOTAL_DIM1 (TOTAL_DIM1),
        .CHANNELS   (CHANNELS)
    ) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_tile      (in_tile),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .weight_tile  (weight_tile),
        .weight_valid (weight_valid),
        .weight_ready (weight_ready),
        .out_tile     (out_tile),
        .out_valid    (out_valid),
        .out_ready    (out_ready)
    );

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_tile(string name, out_tile_t actual, out_tile_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch %s beat %0d: got %h, expected %h",
                                name, out_count, actual, expected));
        end
    endtask

    task automatic check_flag(string name, logic actual, logic expected);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic wait_for_reset(int limit);
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                abort_run("Error: reset was never released");
            end
        end
    endtask

    task automatic wait_drain(int limit);
        int cycles;
        cycles = 0;
        while (in_q.size() != 0 || w_q.size() != 0 || exp_q.size() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                abort_run("Error: timed out waiting for all output tiles to arrive");
            end
        end
    endtask

    function automatic in_vec_t random_inputs();
        in_vec_t x;
        for (int b = 0; b < NUM_ITERS; b++) begin
            for (int l = 0; l < LANES; l++) begin
                x[b].lane[l] = IN_WIDTH'(next_random_bits(IN_WIDTH));
            end
        end
        return x;
    endfunction

    function automatic w_vec_t random_weights();
        w_vec_t w;
        for (int b = 0; b < NUM_ITERS; b++) begin
            for (int l = 0; l < LANES; l++) begin
                w[b].lane[l] = W_WIDTH'(next_random_bits(W_WIDTH));
            end
        end
        return w;
    endfunction

    task automatic queue_vector(in_vec_t x, w_vec_t w);
        out_vec_t y;
        y = expected_vector(x, w);
        for (int b = 0; b < NUM_ITERS; b++) begin
            in_q.push_back(x[b]);
            w_q.push_back(w[b]);
            exp_q.push_back(y[b]);
        end
    endtask

    // Input stream driver holds valid until accepted
    always @(posedge clk) begin
        if (rst_n) begin
            if (in_valid && in_ready) begin
                void'(in_q.pop_front());
            end
            if (!in_valid || in_ready) begin
                if (in_q.size() > 0 && (!gaps_on || next_random_bits(1) != 0)) begin
                    in_valid <= 1'b1;
                    in_tile  <= in_q[0];
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (weight_valid && weight_ready) begin
                void'(w_q.pop_front());
            end
            if (!weight_valid || weight_ready) begin
                if (w_q.size() > 0 && (!gaps_on || next_random_bits(1) != 0)) begin
                    weight_valid <= 1'b1;
                    weight_tile  <= w_q[0];
                end else begin
                    weight_valid <= 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        out_ready <= ready_random ? (next_random_bits(1) != 0) : 1'b1;
    end

    // Monitor compares each accepted output beat in order
    always @(posedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("Error: output tile arrived with no expected tile pending");
            end else begin
                check_tile("out_tile", out_tile, exp_q.pop_front());
                out_count++;
            end
        end
    end

    initial begin
        in_vec_t x;
        w_vec_t  w;
        in_tile      = '0;
        in_valid     = 1'b0;
        weight_tile  = '0;
        weight_valid = 1'b0;
        out_ready    = 1'b1;
        gaps_on      = 1'b0;
        ready_random = 1'b0;
        out_count    = 0;
        wait_for_reset(20);

        // Idle after reset
        repeat (20) begin
            @(negedge clk);
            check_flag("out_valid", out_valid, 1'b0);
            check_flag("in_ready", in_ready, 1'b1);
            check_flag("weight_ready", weight_ready, 1'b0);
        end

        // Constant vector of 1.5 with weight 1.0
        for (int b = 0; b < NUM_ITERS; b++) begin
            for (int l = 0; l < LANES; l++) begin
                x[b].lane[l] = 8'h06;
                w[b].lane[l] = 8'h04;
            end
        end
        queue_vector(x, w);
        wait_drain(2000);

        // Back-to-back random vectors
        repeat (8) queue_vector(random_inputs(), random_weights());
        wait_drain(4000);

        // Gaps on both inputs and random back-pressure
        gaps_on      = 1'b1;
        ready_random = 1'b1;
        repeat (6) queue_vector(random_inputs(), random_weights());
        wait_drain(10000);
        gaps_on      = 1'b0;
        ready_random = 1'b0;

        // All-zero vector hits the saturated inverse root
        queue_vector('0, random_weights());
        // Small values with extreme weights saturate both ways
        for (int b = 0; b < NUM_ITERS; b++) begin
            for (int l = 0; l < LANES; l++) begin
                x[b].lane[l] = ((b + l) % 2 == 0) ? 8'h01 : 8'hFF;
                w[b].lane[l] = (l % 2 == 0) ? 8'h7F : 8'h80;
            end
        end
        queue_vector(x, w);
        wait_drain(2000);

        // Nothing extra after the last vector
        repeat (10) begin
            @(negedge clk);
            check_flag("out_valid", out_valid, 1'b0);
            check_flag("in_ready", in_ready, 1'b1);
            check_flag("weight_ready", weight_ready, 1'b0);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+sim
verilog/rms_norm_pkg.sv
verilog/tile_fifo.sv
verilog/square_accumulator.sv
verilog/inv_sqrt.sv
verilog/norm_scale.sv
verilog/rms_norm_2d.sv
sim/clock_gen.sv
sim/tb_rms_norm.sv

/* verilog/inv_sqrt.sv */
// Inverse square root of the mean square
// Restoring shift-subtract square root of mean*16, two radicand bits per
// cycle, then a restoring division of 4096 by the root, one quotient
// bit per cycle. The result is held until the scaling stage releases it.

`timescale 1ns/10ps
`default_nettype none

module inv_sqrt (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rms_norm_pkg::ms_t    mean,
    input  logic                 mean_valid,
    output logic                 mean_ready,
    output rms_norm_pkg::isqrt_t isqrt,
    output logic                 isqrt_valid,
    input  logic                 isqrt_ready
);
    import rms_norm_pkg::*;

    localparam int ROOT_CYCLES = 12;
    localparam int RAD_W       = 2 * ROOT_CYCLES;
    localparam int REM_W       = 16;
    localparam logic [3:0] ROOT_LAST = 4'(ROOT_CYCLES - 1);
    localparam logic [3:0] DIV_LAST  = 4'(ISQRT_WIDTH - 1);
    // 1.0 in Q8 divided by a Q4 root
    localparam logic [ISQRT_WIDTH-1:0] DIVIDEND = ISQRT_WIDTH'(1) << (ISQRT_FRAC + MS_FRAC);

    isqrt_state_e           state_q;
    logic [3:0]             cnt_q;
    logic [RAD_W-1:0]       rad_q;
    logic [ROOT_CYCLES-1:0] root_q;
    logic [REM_W-1:0]       rem_q;
    logic [ISQRT_WIDTH-1:0] quot_q;
    logic [REM_W-1:0]       rem_s;
    logic [REM_W-1:0]       trial;
    logic [REM_W-1:0]       rem_d;
    logic [REM_W-1:0]       divisor;
    logic                   root_bit;
    logic                   quot_bit;

    assign mean_ready = (state_q == ST_IDLE);
    assign isqrt      = quot_q;

    always_comb begin
        rem_s    = {rem_q[REM_W-3:0], rad_q[RAD_W-1 -: 2]};
        trial    = {2'b00, root_q, 2'b01};
        root_bit = (rem_s >= trial);
        // A zero root takes every subtract, so the quotient saturates to all ones
        divisor  = REM_W'(root_q);
        rem_d    = {rem_q[REM_W-2:0], quot_q[ISQRT_WIDTH-1]};
        quot_bit = (rem_d >= divisor);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= ST_IDLE;
            cnt_q       <= '0;
            isqrt_valid <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (mean_valid) begin
                        state_q <= ST_ROOT;
                        cnt_q   <= '0;
                    end
                end
                ST_ROOT: begin
                    cnt_q <= (cnt_q == ROOT_LAST) ? '0 : cnt_q + 4'd1;
                    if (cnt_q == ROOT_LAST) begin
                        state_q <= ST_DIVIDE;
                    end
                end
                ST_DIVIDE: begin
                    cnt_q <= cnt_q + 4'd1;
                    if (cnt_q == DIV_LAST) begin
                        state_q     <= ST_HOLD;
                        isqrt_valid <= 1'b1;
                    end
                end
                ST_HOLD: begin
                    if (isqrt_ready) begin
                        state_q     <= ST_IDLE;
                        isqrt_valid <= 1'b0;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            ST_IDLE: begin
                rad_q  <= RAD_W'({mean, {MS_FRAC{1'b0}}});
                root_q <= '0;
                rem_q  <= '0;
            end
            ST_ROOT: begin
                rad_q  <= rad_q << 2;
                root_q <= {root_q[ROOT_CYCLES-2:0], root_bit};
                rem_q  <= root_bit ? rem_s - trial : rem_s;
                // Set up the divider on the last root step
                if (cnt_q == ROOT_LAST) begin
                    rem_q  <= '0;
                    quot_q <= DIVIDEND;
                end
            end
            ST_DIVIDE: begin
                rem_q  <= quot_bit ? rem_d - divisor : rem_d;
                quot_q <= {quot_q[ISQRT_WIDTH-2:0], quot_bit};
            end
            default: ;
        endcase
    end

    a_valid_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
        isqrt_valid |-> (state_q == ST_HOLD));

    a_fixed_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (mean_valid && mean_ready) |-> ##(ROOT_CYCLES + ISQRT_WIDTH + 1) isqrt_valid);

endmodule

`default_nettype wire

/* verilog/norm_scale.sv */
// Normalization and affine scaling stage
// Joins the inverse root, a buffered input tile and a weight tile.
// The root is reused for NUM_ITERS beats and released on the last one.
// Two register stages: the norm product, then the weighted result cast
// to the output format with floor and saturation.

`timescale 1ns/10ps
`default_nettype none

module norm_scale #(
    parameter int NUM_ITERS = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rms_norm_pkg::isqrt_t    isqrt,
    input  logic                    isqrt_valid,
    output logic                    isqrt_ready,
    input  rms_norm_pkg::in_tile_t  tile,
    input  logic                    tile_valid,
    output logic                    tile_ready,
    input  rms_norm_pkg::w_tile_t   weight,
    input  logic                    weight_valid,
    output logic                    weight_ready,
    output rms_norm_pkg::out_tile_t out_tile,
    output logic                    out_valid,
    input  logic                    out_ready
);
    import rms_norm_pkg::*;

    localparam int NORM_W     = ISQRT_WIDTH + 1 + IN_WIDTH;
    localparam int AFF_W      = NORM_W + W_WIDTH;
    // Q12 affine value down to the Q4 output
    localparam int CAST_SHIFT = ISQRT_FRAC + IN_FRAC + W_FRAC - OUT_FRAC;
    localparam int OUT_MAX    = 2 ** (OUT_WIDTH - 1) - 1;
    localparam int OUT_MIN    = -(2 ** (OUT_WIDTH - 1));
    localparam int CNT_W      = (NUM_ITERS > 1) ? $clog2(NUM_ITERS) : 1;
    localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(NUM_ITERS - 1);

    logic [CNT_W-1:0]             beat_q;
    logic                         last_beat;
    logic                         join_fire;
    logic                         norm_en;
    logic                         out_en;
    logic                         norm_valid;
    logic [LANES-1:0][NORM_W-1:0] norm_d;
    logic [LANES-1:0][NORM_W-1:0] norm_q;
    w_tile_t                      weight_q;
    logic signed [AFF_W-1:0]      affine  [LANES];
    logic signed [AFF_W-1:0]      shifted [LANES];
    out_tile_t                    out_d;

    assign out_en    = !out_valid || out_ready;
    assign norm_en   = !norm_valid || out_en;
    assign last_beat = (beat_q == LAST_BEAT);

    // Three-way join, the root stays on its input until the last beat
    assign join_fire    = isqrt_valid && tile_valid && weight_valid && norm_en;
    assign tile_ready   = isqrt_valid && weight_valid && norm_en;
    assign weight_ready = isqrt_valid && tile_valid && norm_en;
    assign isqrt_ready  = tile_valid && weight_valid && norm_en && last_beat;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            norm_d[i]  = $signed({1'b0, isqrt}) * $signed(tile.lane[i]);
            affine[i]  = $signed(norm_q[i]) * $signed(weight_q.lane[i]);
            shifted[i] = affine[i] >>> CAST_SHIFT;
            if (shifted[i] > OUT_MAX) begin
                out_d.lane[i] = OUT_WIDTH'(OUT_MAX);
            end else if (shifted[i] < OUT_MIN) begin
                out_d.lane[i] = OUT_WIDTH'(OUT_MIN);
            end else begin
                out_d.lane[i] = shifted[i][OUT_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_q     <= '0;
            norm_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            if (norm_en) begin
                norm_valid <= join_fire;
            end
            if (out_en) begin
                out_valid <= norm_valid;
            end
            if (join_fire) begin
                beat_q <= last_beat ? '0 : beat_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (join_fire) begin
            norm_q   <= norm_d;
            weight_q <= weight;
        end
        if (out_en && norm_valid) begin
            out_tile <= out_d;
        end
    end

    a_out_held: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_tile)));

endmodule

`default_nettype wire

/* verilog/rms_norm_2d.sv */
// RMS normalization top level
// Splits the input tile stream into a buffer and the statistics path,
// computes the inverse RMS per vector and scales every buffered tile by
// it and by its weight tile. Output tiles leave in input order.

`timescale 1ns/10ps
`default_nettype none

module rms_norm_2d #(
    parameter int TOTAL_DIM0 = 4,
    parameter int TOTAL_DIM1 = 4,
    parameter int CHANNELS   = 2
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rms_norm_pkg::in_tile_t  in_tile,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  rms_norm_pkg::w_tile_t   weight_tile,
    input  logic                    weight_valid,
    output logic                    weight_ready,
    output rms_norm_pkg::out_tile_t out_tile,
    output logic                    out_valid,
    input  logic                    out_ready
);
    import rms_norm_pkg::*;

    localparam int NUM_ITERS  = TOTAL_DIM0 * TOTAL_DIM1 * CHANNELS / LANES;
    localparam int NUM_VALUES = NUM_ITERS * LANES;
    // Room for one vector plus the next while its root is computed
    localparam int FIFO_DEPTH = 2 * NUM_ITERS;

    logic     fifo_wr_valid;
    logic     fifo_wr_ready;
    in_tile_t fifo_rd_tile;
    logic     fifo_rd_valid;
    logic     fifo_rd_ready;
    logic     sq_valid;
    logic     sq_ready;
    ms_t      mean;
    logic     mean_valid;
    logic     mean_ready;
    isqrt_t   isqrt;
    logic     isqrt_valid;
    logic     isqrt_ready;

    // Each beat enters both branches in the same cycle
    assign in_ready      = fifo_wr_ready && sq_ready;
    assign fifo_wr_valid = in_valid && sq_ready;
    assign sq_valid      = in_valid && fifo_wr_ready;

    tile_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_tile_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_tile  (in_tile),
        .wr_valid (fifo_wr_valid),
        .wr_ready (fifo_wr_ready),
        .rd_tile  (fifo_rd_tile),
        .rd_valid (fifo_rd_valid),
        .rd_ready (fifo_rd_ready)
    );

    square_accumulator #(
        .NUM_ITERS  (NUM_ITERS),
        .NUM_VALUES (NUM_VALUES)
    ) u_square_accumulator (
        .clk        (clk),
        .rst_n      (rst_n),
        .tile       (in_tile),
        .tile_valid (sq_valid),
        .tile_ready (sq_ready),
        .mean       (mean),
        .mean_valid (mean_valid),
        .mean_ready (mean_ready)
    );

    inv_sqrt u_inv_sqrt (
        .clk         (clk),
        .rst_n       (rst_n),
        .mean        (mean),
        .mean_valid  (mean_valid),
        .mean_ready  (mean_ready),
        .isqrt       (isqrt),
        .isqrt_valid (isqrt_valid),
        .isqrt_ready (isqrt_ready)
    );

    norm_scale #(
        .NUM_ITERS (NUM_ITERS)
    ) u_norm_scale (
        .clk          (clk),
        .rst_n        (rst_n),
        .isqrt        (isqrt),
        .isqrt_valid  (isqrt_valid),
        .isqrt_ready  (isqrt_ready),
        .tile         (fifo_rd_tile),
        .tile_valid   (fifo_rd_valid),
        .tile_ready   (fifo_rd_ready),
        .weight       (weight_tile),
        .weight_valid (weight_valid),
        .weight_ready (weight_ready),
        .out_tile     (out_tile),
        .out_valid    (out_valid),
        .out_ready    (out_ready)
    );

endmodule

`default_nettype wire

/* verilog/rms_norm_pkg.sv */
// RMS normalization shared definitions
// Fixed lane count and fixed-point formats, the tile payload structs
// and the state encoding of the inverse-root sequencer.

`default_nettype none

package rms_norm_pkg;

    // One beat is a 2x2 tile
    localparam int LANES       = 4;

    localparam int IN_WIDTH    = 8;
    localparam int IN_FRAC     = 2;
    localparam int W_WIDTH     = 8;
    localparam int W_FRAC      = 2;
    localparam int OUT_WIDTH   = 8;
    localparam int OUT_FRAC    = 4;

    // Square and accumulator formats, both with 2*IN_FRAC fraction bits
    localparam int SQ_WIDTH    = 16;
    localparam int ACC_WIDTH   = 32;

    localparam int MS_WIDTH    = 16;
    localparam int MS_FRAC     = 4;
    localparam int ISQRT_WIDTH = 16;
    localparam int ISQRT_FRAC  = 8;

    typedef struct packed {
        logic signed [LANES-1:0][IN_WIDTH-1:0] lane;
    } in_tile_t;

    typedef struct packed {
        logic signed [LANES-1:0][W_WIDTH-1:0] lane;
    } w_tile_t;

    typedef struct packed {
        logic signed [LANES-1:0][OUT_WIDTH-1:0] lane;
    } out_tile_t;

    typedef logic [MS_WIDTH-1:0]    ms_t;
    typedef logic [ISQRT_WIDTH-1:0] isqrt_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ROOT,
        ST_DIVIDE,
        ST_HOLD
    } isqrt_state_e;

endpackage

`default_nettype wire

/* verilog/square_accumulator.sv */
// Mean-square statistics stage
// Squares the lanes of each beat, reduces them and accumulates over a
// vector of NUM_ITERS beats. The sum is scaled by a fixed reciprocal of
// NUM_VALUES and clamped, then held until the root stage takes it.

`timescale 1ns/10ps
`default_nettype none

module square_accumulator #(
    parameter int NUM_ITERS  = 8,
    parameter int NUM_VALUES = 32
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rms_norm_pkg::in_tile_t tile,
    input  logic                   tile_valid,
    output logic                   tile_ready,
    output rms_norm_pkg::ms_t      mean,
    output logic                   mean_valid,
    input  logic                   mean_ready
);
    import rms_norm_pkg::*;

    localparam int CNT_W = (NUM_ITERS > 1) ? $clog2(NUM_ITERS) : 1;
    localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(NUM_ITERS - 1);
    // floor(2^32 / N), one bit wider than the accumulator
    localparam logic [63:0] RECIP_FULL = (64'd1 << ACC_WIDTH) / NUM_VALUES;
    localparam logic [ACC_WIDTH:0] RECIP = RECIP_FULL[ACC_WIDTH:0];

    logic                           hold;
    logic                           tile_fire;
    logic [CNT_W-1:0]               cnt_q;
    logic [LANES-1:0][SQ_WIDTH-1:0] sq_d;
    logic [LANES-1:0][SQ_WIDTH-1:0] sq_q;
    logic                           sq_valid;
    logic                           sq_first;
    logic                           sq_last;
    logic [ACC_WIDTH-1:0]           lane_sum;
    logic [ACC_WIDTH-1:0]           acc_q;
    logic [2*ACC_WIDTH:0]           scaled;
    logic [ACC_WIDTH:0]             ms_full;

    // Whole stage freezes while a finished mean waits
    assign hold       = mean_valid && !mean_ready;
    assign tile_ready = !hold;
    assign tile_fire  = tile_valid && tile_ready;

    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < LANES; i++) begin
            sq_d[i]  = $signed(tile.lane[i]) * $signed(tile.lane[i]);
            lane_sum = lane_sum + sq_q[i];
        end
    end

    assign scaled  = acc_q * RECIP;
    assign ms_full = scaled[2*ACC_WIDTH:ACC_WIDTH];
    assign mean    = (ms_full > ACC_WIDTH'(2**MS_WIDTH - 1)) ? '1 : ms_full[MS_WIDTH-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q      <= '0;
            sq_valid   <= 1'b0;
            sq_first   <= 1'b0;
            sq_last    <= 1'b0;
            mean_valid <= 1'b0;
        end else begin
            if (!hold) begin
                sq_valid <= tile_fire;
            end
            if (tile_fire) begin
                sq_first <= (cnt_q == '0);
                sq_last  <= (cnt_q == LAST_BEAT);
                cnt_q    <= (cnt_q == LAST_BEAT) ? '0 : cnt_q + 1'b1;
            end
            if (mean_ready) begin
                mean_valid <= 1'b0;
            end
            if (!hold && sq_valid && sq_last) begin
                mean_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tile_fire) begin
            sq_q <= sq_d;
        end
        // First beat of a vector restarts the sum
        if (!hold && sq_valid) begin
            acc_q <= (sq_first ? '0 : acc_q) + lane_sum;
        end
    end

    a_beat_range: assert property (@(posedge clk) disable iff (!rst_n)
        cnt_q <= LAST_BEAT);

    a_mean_held: assert property (@(posedge clk) disable iff (!rst_n)
        (mean_valid && !mean_ready) |=> (mean_valid && $stable(mean)));

endmodule

`default_nettype wire

/* verilog/tile_fifo.sv */
// Input tile buffer
// Circular buffer that keeps the tiles of a vector, and part of the
// next one, until their inverse root is known.

`timescale 1ns/10ps
`default_nettype none

module tile_fifo #(
    parameter int DEPTH = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rms_norm_pkg::in_tile_t wr_tile,
    input  logic                   wr_valid,
    output logic                   wr_ready,
    output rms_norm_pkg::in_tile_t rd_tile,
    output logic                   rd_valid,
    input  logic                   rd_ready
);
    import rms_norm_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL      = CNT_W'(DEPTH);

    in_tile_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_fire;
    logic             rd_fire;

    assign wr_ready = (count != FULL);
    assign rd_valid = (count != '0);
    assign rd_tile  = mem[rd_ptr];
    assign wr_fire  = wr_valid && wr_ready;
    assign rd_fire  = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr_tile;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // Occupancy stays in range and agrees with the pointers
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        (count <= FULL) && ((wr_ptr == rd_ptr) == (count == '0 || count == FULL)));

endmodule

`default_nettype wire
